// ==== bench/tb_up.sv ====
module tb_up import up_pkg::*; ();

	logic clk;
	logic nRst;
	logic run;
	logic intr;
	load_t load;
	logic halted;
	logic obs_we;
	logic [WORD_W-1:0] obs_addr;
	logic [WORD_W-1:0] obs_data;

	logic [15:0] core_q[$];  // expected {addr, data} of core stores, in order.
	logic [15:0] load_q[$];
	logic [15:0] core_head;
	logic [15:0] load_head;
	logic core_have;
	logic load_have;
	logic checking;
	logic [7:0] prog[$];
	string test_name;
	int errors;
	int errors_base;
	int tests_run;
	int tests_failed;
	integer seed;

	up_top i_up_top (
		.clk(clk), .nRst(nRst), .run(run), .intr(intr), .load(load), .halted(halted),
		.obs_we(obs_we), .obs_addr(obs_addr), .obs_data(obs_data)
	);

	always #20 clk = ~clk;

	function automatic logic in_load_region(input logic [7:0] a);
		return a[7:5] == 3'b110;  // loader traffic goes to C0..DF.
	endfunction

	task automatic refresh_heads();
		core_have = core_q.size() > 0;
		core_head = core_have ? core_q[0] : 16'h0000;
		load_have = load_q.size() > 0;
		load_head = load_have ? load_q[0] : 16'h0000;
	endtask

	task automatic report_store(input string who, input logic have, input logic [15:0] exp,
			input logic [15:0] act);
		errors++;
		if (!have)
			$display("%s: unexpected %s store of %h at address %h", test_name, who, act[7:0],
				act[15:8]);
		else
			$display("mismatch %s expected %h actual %h", test_name, exp, act);
	endtask

	always @(posedge clk) begin
		if (nRst && checking && obs_we) begin
			if (in_load_region(obs_addr)) begin
				if (load_q.size() > 0)
					void'(load_q.pop_front());
			end else if (core_q.size() > 0) begin
				void'(core_q.pop_front());
			end
			refresh_heads();
		end
	end

	a_core_store: assert property (@(posedge clk) disable iff (!nRst || !checking)
		obs_we && !in_load_region(obs_addr) |-> core_have && {obs_addr, obs_data} == core_head)
		else report_store("core", $sampled(core_have), $sampled(core_head),
			{$sampled(obs_addr), $sampled(obs_data)});

	a_load_store: assert property (@(posedge clk) disable iff (!nRst || !checking)
		obs_we && in_load_region(obs_addr) |-> load_have && {obs_addr, obs_data} == load_head)
		else report_store("loader", $sampled(load_have), $sampled(load_head),
			{$sampled(obs_addr), $sampled(obs_data)});

	task automatic emit(input opcode_e op, input int n);
		prog.push_back({op, 4'(n)});
	endtask

	task automatic expect_core(input logic [7:0] a, input logic [7:0] d);
		core_q.push_back({a, d});
		refresh_heads();
	endtask

	task automatic write_program(input logic [7:0] base);
		foreach (prog[i]) begin
			@(posedge clk);
			load <= '{stb: 1'b1, addr: base + 8'(i), data: prog[i]};
		end
		@(posedge clk);
		load <= '0;
		prog.delete();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_base = errors;
		@(posedge clk);
		nRst <= 1'b0;
		run <= 1'b0;
		intr <= 1'b0;
		load <= '0;
		checking <= 1'b0;
		repeat (4) @(posedge clk);
		nRst <= 1'b1;
		emit(OP_LDI, 8);  // every program starts at 10, with r7 = 10.
		emit(OP_MOV, 7);
		emit(OP_ADD, 7);
		emit(OP_MOV, 7);
		emit(OP_JMP, 7);
		write_program(8'h00);
	endtask

	task automatic start_run();
		@(posedge clk);
		checking <= 1'b1;
		run <= 1'b1;
	endtask

	task automatic wait_halted();
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < 2000 && !seen; i++) begin
			@(negedge clk);
			seen = halted;
		end
		if (!seen) begin
			errors++;
			$display("%s: timed out waiting for the core to halt", test_name);
		end
	endtask

	task automatic end_test();
		wait_halted();
		@(posedge clk);
		checking <= 1'b0;
		run <= 1'b0;
		if (core_q.size() != 0 || load_q.size() != 0) begin
			errors++;
			$display("%s: %0d expected stores never appeared", test_name,
				core_q.size() + load_q.size());
		end
		core_q.delete();
		load_q.delete();
		refresh_heads();
		tests_run++;
		if (errors > errors_base) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - errors_base);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	// r1 = 7, r3..r7 hold addresses 5..9, each result is 5 op 7.
	task automatic build_alu_program();
		opcode_e ops[5];
		ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
		emit(OP_LDI, 7);
		emit(OP_MOV, 1);
		for (int k = 0; k < 5; k++) begin
			emit(OP_LDI, 5 + k);
			emit(OP_MOV, 3 + k);
		end
		for (int k = 0; k < 5; k++) begin
			emit(OP_LDI, 5);
			emit(ops[k], 1);
			emit(OP_ST, 3 + k);
		end
		emit(OP_HALT, 0);
	endtask

	task automatic expect_alu_stores();
		logic [7:0] a;
		logic [7:0] b;
		a = 8'd5;
		b = 8'd7;
		expect_core(8'd5, a + b);
		expect_core(8'd6, a - b);
		expect_core(8'd7, a & b);
		expect_core(8'd8, a | b);
		expect_core(8'd9, a ^ b);
	endtask

	task automatic alu_results();
		begin_test("alu");
		build_alu_program();
		write_program(8'h10);
		expect_alu_stores();
		start_run();
		end_test();
	endtask

	task automatic load_store_copy();
		begin_test("load_store");
		for (int k = 0; k < 4; k++) begin
			emit(OP_LDI, 10 + k);
			emit(OP_MOV, 1 + k);
		end
		emit(OP_LDI, 10);
		emit(OP_ST, 1);
		emit(OP_LDI, 3);
		emit(OP_ST, 2);
		emit(OP_LD, 1);
		emit(OP_ST, 3);
		emit(OP_LD, 2);
		emit(OP_ST, 4);
		emit(OP_HALT, 0);
		write_program(8'h10);
		expect_core(8'd10, 8'h0A);
		expect_core(8'd11, 8'h03);
		expect_core(8'd12, 8'h0A);  // read back and copied.
		expect_core(8'd13, 8'h03);
		start_run();
		end_test();
	endtask

	task automatic stack_and_jumps();
		int targets[3];
		begin_test("stack_jumps");
		targets = '{10, 13, 15};  // bad 2A, good 2D, end 2F.
		emit(OP_LDI, 14);
		emit(OP_MOV, 5);
		emit(OP_LDI, 15);
		emit(OP_MOV, 4);
		emit(OP_LDI, 6);
		emit(OP_PUSH, 0);
		emit(OP_LDI, 0);
		emit(OP_POP, 2);
		emit(OP_LDI, 0);
		emit(OP_ADD, 2);
		emit(OP_ST, 5);
		for (int k = 0; k < 3; k++) begin
			emit(OP_LDI, targets[k]);
			emit(OP_ADD, 7);
			emit(OP_ADD, 7);
			emit(OP_MOV, (k == 0) ? 1 : (k == 1) ? 3 : 6);
		end
		emit(OP_JZ, 1);  // r0 is 2F here, must fall through.
		emit(OP_LDI, 0);
		emit(OP_JZ, 3);
		emit(OP_LDI, 11);
		emit(OP_ST, 4);
		emit(OP_HALT, 0);
		emit(OP_JMP, 6);
		emit(OP_JMP, 1);
		emit(OP_LDI, 12);
		emit(OP_ST, 4);
		emit(OP_HALT, 0);
		write_program(8'h10);
		expect_core(SP_RESET, 8'h06);
		expect_core(8'd14, 8'h06);
		expect_core(8'd15, 8'h0C);
		start_run();
		end_test();
	endtask

	task automatic interrupt_entry();
		logic seen;
		begin_test("interrupt");
		emit(OP_JMP, 7);  // spins at 10.
		write_program(8'h10);
		emit(OP_LDI, 9);
		emit(OP_MOV, 2);
		emit(OP_LDI, 5);
		emit(OP_ST, 2);
		emit(OP_HALT, 0);
		write_program(INT_VECTOR);
		expect_core(SP_RESET, 8'h10);
		expect_core(8'd9, 8'h05);
		start_run();
		repeat (30) @(posedge clk);
		intr <= 1'b1;
		seen = 1'b0;
		for (int i = 0; i < 200 && !seen; i++) begin
			@(negedge clk);
			seen = obs_we;
		end
		if (!seen) begin
			errors++;
			$display("%s: no stack write after raising the interrupt", test_name);
		end
		@(posedge clk);
		intr <= 1'b0;
		end_test();
	endtask

	task automatic loader_arbitration();
		int gap;
		int r;
		logic [7:0] a;
		logic [7:0] d;
		begin_test("arbitration");
		build_alu_program();
		write_program(8'h10);
		expect_alu_stores();
		start_run();
		repeat (12) begin
			r = $random(seed);
			gap = 1 + ($random(seed) & 3);
			a = {3'b110, r[4:0]};
			d = r[12:5];
			@(posedge clk);
			load <= '{stb: 1'b1, addr: a, data: d};
			load_q.push_back({a, d});
			refresh_heads();
			@(posedge clk);
			load <= '0;
			repeat (gap) @(posedge clk);
		end
		end_test();
	endtask

	initial begin
		clk = 1'b0;
		nRst = 1'b0;
		run = 1'b0;
		intr = 1'b0;
		load = '0;
		checking = 1'b0;
		errors = 0;
		errors_base = 0;
		tests_run = 0;
		tests_failed = 0;
		seed = 46;
		refresh_heads();
		alu_results();
		load_store_copy();
		stack_and_jumps();
		interrupt_entry();
		loader_arbitration();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		#2000000;
		$display("simulation ran past its time limit");
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== hdl/up_alu.sv ====
module up_alu import up_pkg::*; (
	input alu_op_e op,
	input logic [WORD_W-1:0] a,
	input logic [WORD_W-1:0] b,
	input logic [WORD_W-1:0] pc,
	input logic [WORD_W-1:0] sp,
	input logic [3:0] imm,
	output logic [WORD_W-1:0] y
);

	// a is r0, b is the register named by the instruction.
	always_comb begin
		case (op)
			ALU_PC: y = pc;
			ALU_PC_INC: y = pc + 8'd1;
			ALU_SP_DEC: y = sp - 8'd1;
			ALU_SP_INC: y = sp + 8'd1;
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_REG: y = b;  // jump target or memory address.
			ALU_IMM: y = {4'b0000, imm};
			ALU_ACC: y = a;
			default: y = a;
		endcase
	end

endmodule

// ==== hdl/up_bus_arbiter.sv ====
module up_bus_arbiter import up_pkg::*; (
	input logic clk,
	input logic nRst,
	input bus_req_t core,
	input load_t load,
	output bus_req_t grant,
	output logic core_re,
	input logic mem_re
);

	bus_req_t pend_q;
	logic pend_v;
	logic core_rd_q;
	logic defer;

	assign defer = core.stb & (load.stb | pend_v);  // core cannot go out this cycle.

	always_comb begin
		if (load.stb)
			grant = '{stb: 1'b1, we: 1'b1, addr: load.addr, wdata: load.data};
		else if (pend_v)
			grant = pend_q;
		else
			grant = core;
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pend_v <= 1'b0;
			core_rd_q <= 1'b0;
		end else begin
			core_rd_q <= ~load.stb & grant.stb & ~grant.we;
			if (defer)
				pend_v <= 1'b1;
			else if (!load.stb)
				pend_v <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (defer)
			pend_q <= core;
	end

	assign core_re = mem_re & core_rd_q;

	a_one_deferred: assert property (@(posedge clk) disable iff (!nRst)
		pend_v && load.stb |-> !core.stb);

endmodule

// ==== hdl/up_controller.sv ====
module up_controller import up_pkg::*; (
	input logic clk,
	input logic nRst,
	input logic run,
	input logic intr,
	input opcode_e ir,
	input logic zero,
	input logic mem_re,
	output alu_op_e op,
	output logic ir_we,
	output logic pc_we,
	output logic sp_we,
	output logic rb_we,
	output logic mem_we,
	output logic ale,
	output logic halted,
	output logic [2:0] rb_sel_in
);

	state_e state;

	always_comb begin
		op = ALU_PC;
		ir_we = 1'b0;
		pc_we = 1'b0;
		sp_we = 1'b0;
		rb_we = 1'b0;
		mem_we = 1'b0;
		ale = 1'b0;
		halted = 1'b0;
		rb_sel_in = 3'b000;
		case (state)
			FETCH_LATCH: ale = run & ~intr;  // pc goes out as the fetch address.
			FETCH_READ: begin
				op = ALU_PC_INC;
				ir_we = 1'b1;  // both take effect when the byte arrives.
				pc_we = 1'b1;
			end
			EXECUTE_1: begin
				case (ir)
					OP_LDI: begin
						op = ALU_IMM;
						rb_we = 1'b1;
					end
					OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
						op = (ir == OP_ADD) ? ALU_ADD :
							(ir == OP_SUB) ? ALU_SUB :
							(ir == OP_AND) ? ALU_AND :
							(ir == OP_OR) ? ALU_OR : ALU_XOR;
						rb_we = 1'b1;
					end
					OP_MOV: begin
						op = ALU_ACC;
						rb_we = 1'b1;
						rb_sel_in[RBS_RN] = 1'b1;
					end
					OP_JZ: begin
						op = ALU_REG;
						pc_we = zero;
					end
					OP_JMP: begin
						op = ALU_REG;
						pc_we = 1'b1;
					end
					default: op = ALU_PC;
				endcase
			end
			EXECUTE_2: begin
				case (ir)
					OP_LD: begin
						op = ALU_REG;
						ale = 1'b1;
					end
					OP_ST: begin
						op = ALU_REG;
						mem_we = 1'b1;
					end
					OP_PUSH: begin
						op = ALU_SP_DEC;  // address is the old sp.
						mem_we = 1'b1;
						rb_sel_in[RBS_RN] = 1'b1;
					end
					OP_POP: begin
						op = ALU_SP_INC;
						ale = 1'b1;
					end
					default: op = ALU_PC;
				endcase
			end
			EXECUTE_3: begin
				case (ir)
					OP_LD: begin
						rb_we = 1'b1;
						rb_sel_in[RBS_MEM] = 1'b1;
					end
					OP_PUSH: begin
						op = ALU_SP_DEC;
						sp_we = 1'b1;
					end
					OP_POP: begin
						op = ALU_SP_INC;
						sp_we = 1'b1;
						rb_we = 1'b1;
						rb_sel_in = 3'b011;  // rN gets the popped byte.
					end
					default: op = ALU_PC;
				endcase
			end
			INT_PUSH: begin
				op = ALU_SP_DEC;
				mem_we = 1'b1;
				sp_we = 1'b1;
				pc_we = 1'b1;
				rb_sel_in[RBS_PC] = 1'b1;
			end
			HALTED: halted = 1'b1;
			default: op = ALU_PC;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= FETCH_LATCH;
		end else begin
			case (state)
				FETCH_LATCH: if (run) state <= intr ? INT_PUSH : FETCH_READ;
				FETCH_READ: if (mem_re) state <= EXECUTE_1;
				EXECUTE_1: begin
					case (ir)
						OP_LD, OP_ST, OP_PUSH, OP_POP: state <= EXECUTE_2;
						OP_HALT: state <= HALTED;
						default: state <= FETCH_LATCH;
					endcase
				end
				EXECUTE_2: state <= EXECUTE_3;
				EXECUTE_3: begin
					if (mem_re || !(ir == OP_LD || ir == OP_POP))
						state <= FETCH_LATCH;
				end
				INT_PUSH: state <= FETCH_LATCH;
				HALTED: state <= HALTED;  // only reset leaves.
				default: state <= FETCH_LATCH;
			endcase
		end
	end

	// read data only comes back while a fetch or a load is waiting for it.
	a_read_when_waiting: assert property (@(posedge clk) disable iff (!nRst)
		mem_re |-> state == FETCH_READ || state == EXECUTE_3);

endmodule

// ==== hdl/up_datapath.sv ====
module up_datapath import up_pkg::*; (
	input logic clk,
	input logic nRst,
	input alu_op_e op,
	input logic ir_we,
	input logic pc_we,
	input logic sp_we,
	input logic rb_we,
	input logic mem_we,
	input logic ale,
	input logic [2:0] rb_sel_in,
	input logic [WORD_W-1:0] mem_rdata,
	input logic mem_re,
	output opcode_e ir,
	output logic zero,
	output bus_req_t req
);

	logic [WORD_W-1:0] pc_q;
	logic [WORD_W-1:0] sp_q;
	logic [WORD_W-1:0] ir_q;
	logic [WORD_W-1:0] y;
	logic [WORD_W-1:0] acc;
	logic [WORD_W-1:0] rdata;
	logic [WORD_W-1:0] wdata;
	logic [2:0] wsel;
	logic step;

	// strobes issued while a read is outstanding wait for its data.
	assign step = ~(ir_we | rb_sel_in[RBS_MEM]) | mem_re;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc_q <= '0;
			sp_q <= SP_RESET;
		end else begin
			if (pc_we && step)
				pc_q <= rb_sel_in[RBS_PC] ? INT_VECTOR : y;
			if (sp_we && step)
				sp_q <= y;
		end
	end

	always_ff @(posedge clk) begin
		if (ir_we && step)
			ir_q <= mem_rdata;
	end

	assign ir = opcode_e'(ir_q[7:4]);
	assign zero = (acc == '0);
	assign wsel = rb_sel_in[RBS_RN] ? ir_q[2:0] : 3'd0;
	assign wdata = rb_sel_in[RBS_MEM] ? mem_rdata : y;

	up_alu i_up_alu (.op(op), .a(acc), .b(rdata), .pc(pc_q), .sp(sp_q), .imm(ir_q[3:0]), .y(y));

	up_regbank i_up_regbank (
		.clk(clk),
		.nRst(nRst),
		.we(rb_we & step),
		.wsel(wsel),
		.rsel(ir_q[2:0]),
		.wdata(wdata),
		.rdata(rdata),
		.acc(acc)
	);

	assign req.stb = ale | mem_we;
	assign req.we = mem_we;
	assign req.addr = (op == ALU_SP_DEC) ? sp_q : y;  // a push writes at sp, then moves it.
	assign req.wdata = rb_sel_in[RBS_PC] ? pc_q : (rb_sel_in[RBS_RN] ? rdata : acc);

endmodule

// ==== hdl/up_memory.sv ====
module up_memory import up_pkg::*; (
	input logic clk,
	input bus_req_t req,
	output logic [WORD_W-1:0] rdata,
	output logic re
);

	logic [WORD_W-1:0] mem [2**WORD_W];
	logic [WORD_W-1:0] addr_q;
	logic rd_q;

	always_ff @(posedge clk) begin
		if (req.stb)
			addr_q <= req.addr;
		if (req.stb && req.we)
			mem[req.addr] <= req.wdata;
		rd_q <= req.stb & ~req.we;
	end

	// read data is valid in the cycle after the grant.
	assign rdata = mem[addr_q];
	assign re = rd_q;

endmodule

// ==== hdl/up_pkg.sv ====
package up_pkg;
	localparam int WORD_W = 8;
	localparam int REG_N = 8;
	localparam logic [WORD_W-1:0] INT_VECTOR = 8'hF0;
	localparam logic [WORD_W-1:0] SP_RESET = 8'hEF;  // stack grows downward from here.

	// bit positions inside rb_sel_in.
	localparam int RBS_RN = 0;  // register port is rN instead of r0.
	localparam int RBS_MEM = 1;  // register write data comes from memory.
	localparam int RBS_PC = 2;  // store data is pc, pc takes the vector.

	typedef enum logic [3:0] {
		OP_NOP = 4'b0000,
		OP_LDI = 4'b0001,
		OP_ADD = 4'b0010,
		OP_SUB = 4'b0011,
		OP_LD = 4'b0100,
		OP_ST = 4'b0101,
		OP_PUSH = 4'b0110,
		OP_POP = 4'b0111,
		OP_MOV = 4'b1000,
		OP_AND = 4'b1001,
		OP_OR = 4'b1010,
		OP_XOR = 4'b1011,
		OP_JZ = 4'b1100,
		OP_JMP = 4'b1101,
		OP_HALT = 4'b1111
	} opcode_e;

	typedef enum logic [2:0] {
		FETCH_LATCH,
		FETCH_READ,
		EXECUTE_1,
		EXECUTE_2,
		EXECUTE_3,
		INT_PUSH,
		HALTED
	} state_e;

	typedef enum logic [4:0] {
		ALU_PC,
		ALU_PC_INC,
		ALU_SP_DEC,
		ALU_SP_INC,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_REG,
		ALU_IMM,
		ALU_ACC
	} alu_op_e;

	typedef struct packed {
		logic stb;
		logic we;
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic stb;
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] data;
	} load_t;
endpackage

// ==== hdl/up_regbank.sv ====
module up_regbank import up_pkg::*; (
	input logic clk,
	input logic nRst,
	input logic we,
	input logic [$clog2(REG_N)-1:0] wsel,
	input logic [$clog2(REG_N)-1:0] rsel,
	input logic [WORD_W-1:0] wdata,
	output logic [WORD_W-1:0] rdata,
	output logic [WORD_W-1:0] acc
);

	logic [WORD_W-1:0] regs [REG_N];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wsel] <= wdata;
		end
	end

	assign rdata = regs[rsel];
	assign acc = regs[0];  // r0 is the accumulator.

endmodule

// ==== hdl/up_top.sv ====
module up_top import up_pkg::*; (
	input logic clk,
	input logic nRst,
	input logic run,
	input logic intr,
	input load_t load,
	output logic halted,
	output logic obs_we,
	output logic [WORD_W-1:0] obs_addr,
	output logic [WORD_W-1:0] obs_data
);

	alu_op_e op;
	opcode_e ir;
	logic ir_we;
	logic pc_we;
	logic sp_we;
	logic rb_we;
	logic mem_we;
	logic ale;
	logic zero;
	logic [2:0] rb_sel_in;
	bus_req_t core_req;
	bus_req_t grant;
	logic [WORD_W-1:0] mem_rdata;
	logic mem_re;
	logic core_re;

	up_controller i_up_controller (
		.clk(clk), .nRst(nRst), .run(run), .intr(intr), .ir(ir), .zero(zero), .mem_re(core_re),
		.op(op), .ir_we(ir_we), .pc_we(pc_we), .sp_we(sp_we), .rb_we(rb_we), .mem_we(mem_we),
		.ale(ale), .halted(halted), .rb_sel_in(rb_sel_in)
	);

	up_datapath i_up_datapath (
		.clk(clk), .nRst(nRst), .op(op), .ir_we(ir_we), .pc_we(pc_we), .sp_we(sp_we),
		.rb_we(rb_we), .mem_we(mem_we), .ale(ale), .rb_sel_in(rb_sel_in),
		.mem_rdata(mem_rdata), .mem_re(core_re), .ir(ir), .zero(zero), .req(core_req)
	);

	up_bus_arbiter i_up_bus_arbiter (
		.clk(clk), .nRst(nRst), .core(core_req), .load(load), .grant(grant),
		.core_re(core_re), .mem_re(mem_re)
	);

	up_memory i_up_memory (.clk(clk), .req(grant), .rdata(mem_rdata), .re(mem_re));

	assign obs_we = grant.stb & grant.we;  // the memory commits this write at the next edge.
	assign obs_addr = grant.addr;
	assign obs_data = grant.wdata;

endmodule

// ==== project.f ====
hdl/up_pkg.sv
hdl/up_alu.sv
hdl/up_regbank.sv
hdl/up_controller.sv
hdl/up_datapath.sv
hdl/up_bus_arbiter.sv
hdl/up_memory.sv
hdl/up_top.sv
bench/tb_up.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_up -o tb_up_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out="$(./obj_dir/tb_up_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1
